// File: all.f
+incdir+hw
test/tb_autotest.sv
hw/at_pkg.sv
hw/sd_fetch_if.sv
hw/sd_byte_fetcher.sv
hw/ctrl_block_reader.sv
hw/feed_streamer.sv
hw/result_checker.sv
hw/test_sequencer.sv
hw/autotest_top.sv
test/autotest_props.sv

// File: hw/at_cfg.svh
// autotest configuration
// sizes, card signature, first control block and UUT timeout
`ifndef AT_CFG_SVH
`define AT_CFG_SVH

// feed word and result widths in bytes
`define AT_FEED_BYTES 4
`define AT_RESULT_BYTES 4

// sd card geometry
`define AT_BLOCK_BYTES 512

// control block header: signature, next block, total bytes, expected result
`define AT_HDR_BYTES (12 + `AT_RESULT_BYTES)

// valid control block mark
`define AT_SIGNATURE 32'hAABB_CCDD

// first control block of the chain
`define AT_START_BLOCK 32'h0010_0000

// cycles the UUT gets to finish after the last feed word
`define AT_TIMEOUT_CYCLES 2000

`endif

// File: hw/at_pkg.sv
// autotest types
// card bytes, block addresses, feed and result words,
// control block header with its byte and field views, sequencer phases
`include "at_cfg.svh"

package at_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [31:0] block_addr_t;
  typedef logic [8*`AT_FEED_BYTES-1:0] feed_word_t;
  typedef logic [8*`AT_RESULT_BYTES-1:0] result_t;

  // header fields in card order, byte 0 most significant
  typedef struct packed {
    logic [31:0] signature;
    block_addr_t next_block;
    logic [31:0] total_bytes;
    result_t     expected;
  } ctrl_hdr_t;

  // bytes[0] is card offset 0 and lands in the top of signature
  typedef union packed {
    byte_t [0:`AT_HDR_BYTES-1] bytes;
    ctrl_hdr_t                 fields;
  } ctrl_block_u;

  typedef enum logic [2:0] {
    INIT,
    READ_HDR,
    FEED,
    WAIT_RESULT,
    NEXT,
    HALT
  } phase_e;

endpackage

// File: hw/autotest_top.sv
// autotest top level
// sd byte fetcher and test sequencer joined by one fetch link
module autotest_top (
  input  logic                clk,
  input  logic                rst,
  // sd host
  input  logic                spi_busy_i,
  input  at_pkg::byte_t       spi_data_out_i,
  output at_pkg::block_addr_t spi_block_addr_o,
  output logic                spi_r_block_o,
  output logic                spi_r_byte_o,
  output logic                spi_r_multi_block_o,
  output logic                spi_rst_o,
  // UUT control and data
  output logic                rst_uut_o,
  input  logic                busy_uut_i,
  input  logic                end_uut_i,
  input  logic                err_uut_i,
  output at_pkg::feed_word_t  feed_data_uut_o,
  output logic                feed_data_control_uut_o,
  output logic                stop_feed_uut_o,
  input  at_pkg::result_t     output_from_uut_i,
  // status
  output logic [31:0]         error_count_o,
  output logic [31:0]         tests_done_o,
  output logic                halted_o
);

  sd_fetch_if fetch_if ();

  sd_byte_fetcher u_fetcher (
    .clk, .rst, .fetch(fetch_if.fetcher), .spi_busy_i, .spi_data_out_i,
    .spi_block_addr_o, .spi_r_block_o, .spi_r_multi_block_o, .spi_r_byte_o
  );

  test_sequencer u_sequencer (
    .clk, .rst, .fetch(fetch_if.requester), .spi_busy_i, .spi_rst_o, .rst_uut_o,
    .busy_uut_i, .end_uut_i, .err_uut_i, .output_from_uut_i, .feed_data_uut_o,
    .feed_data_control_uut_o, .stop_feed_uut_o, .error_count_o, .tests_done_o,
    .halted_o
  );

endmodule

// File: hw/ctrl_block_reader.sv
// control block reader
// reads one whole block in a single-block session, keeps the header
// bytes and flags whether the signature is valid
`include "at_cfg.svh"

module ctrl_block_reader (
  input  logic                clk,
  input  logic                rst,
  input  logic                start_i,
  input  at_pkg::block_addr_t block_addr_i,
  sd_fetch_if.requester       fetch,
  output at_pkg::ctrl_block_u hdr_o,
  output logic                done_o,
  output logic                sig_ok_o
);

  localparam int unsigned CW = $clog2(`AT_BLOCK_BYTES);

  localparam logic [1:0] R_IDLE = 2'd0;
  localparam logic [1:0] R_OPEN = 2'd1;
  localparam logic [1:0] R_PULL = 2'd2;
  localparam logic [1:0] R_WAIT = 2'd3;

  logic [1:0]    state;
  logic [CW-1:0] cnt;
  logic          last_byte;

  assign last_byte = cnt == CW'(`AT_BLOCK_BYTES - 1);

  assign fetch.multi      = 1'b0;
  assign fetch.block_addr = block_addr_i;
  assign fetch.open       = (state == R_OPEN) && fetch.ready;
  assign fetch.pull       = (state == R_PULL) && fetch.ready;
  // fetcher is back in ready on the byte_valid cycle, so close goes out then
  assign fetch.close      = (state == R_WAIT) && fetch.byte_valid && last_byte;

  assign sig_ok_o = hdr_o.fields.signature == `AT_SIGNATURE;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= R_IDLE;
      cnt    <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        R_IDLE: if (start_i) begin
          cnt   <= '0;
          state <= R_OPEN;
        end
        R_OPEN: if (fetch.ready) state <= R_PULL;
        R_PULL: if (fetch.ready) state <= R_WAIT;
        R_WAIT: if (fetch.byte_valid) begin
          cnt <= cnt + 1'b1;
          if (last_byte) begin
            done_o <= 1'b1;
            state  <= R_IDLE;
          end else begin
            state <= R_PULL;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  // header bytes go in by card offset, the rest of the block is skipped
  always_ff @(posedge clk) begin
    if (state == R_WAIT && fetch.byte_valid && cnt < CW'(`AT_HDR_BYTES)) begin
      hdr_o.bytes[cnt] <= fetch.data;
    end
  end

endmodule

// File: hw/feed_streamer.sv
// feed streamer
// pulls feed bytes over a multi-block session, packs them big-endian
// into words and strobes each word into the UUT when it is not busy
`include "at_cfg.svh"

module feed_streamer (
  input  logic                clk,
  input  logic                rst,
  input  logic                start_i,
  input  at_pkg::block_addr_t block_addr_i,
  input  logic [31:0]         total_bytes_i,
  sd_fetch_if.requester       fetch,
  input  logic                busy_uut_i,
  output at_pkg::feed_word_t  feed_data_uut_o,
  output logic                feed_data_control_uut_o,
  output logic                stop_feed_uut_o,
  output logic                done_o
);

  localparam int unsigned LW = $clog2(`AT_FEED_BYTES);

  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_OPEN = 3'd1;
  localparam logic [2:0] S_PULL = 3'd2;
  localparam logic [2:0] S_WAIT = 3'd3;
  localparam logic [2:0] S_FEED = 3'd4;

  logic [2:0]    state;
  logic [31:0]   byte_cnt;
  logic [LW-1:0] lane;
  logic          all_fed;

  assign all_fed = byte_cnt == total_bytes_i;

  assign fetch.multi      = 1'b1;
  assign fetch.block_addr = block_addr_i;
  assign fetch.open       = (state == S_OPEN) && fetch.ready;
  assign fetch.pull       = (state == S_PULL) && fetch.ready && !all_fed;
  assign fetch.close      = (state == S_PULL) && fetch.ready && all_fed;

  // word held in S_FEED until the UUT drops busy
  assign feed_data_control_uut_o = (state == S_FEED) && !busy_uut_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= S_IDLE;
      byte_cnt        <= '0;
      lane            <= '0;
      stop_feed_uut_o <= 1'b0;
      done_o          <= 1'b0;
    end else begin
      stop_feed_uut_o <= 1'b0;
      done_o          <= 1'b0;
      case (state)
        S_IDLE: if (start_i) begin
          byte_cnt <= '0;
          lane     <= '0;
          state    <= S_OPEN;
        end
        S_OPEN: if (fetch.ready) state <= S_PULL;
        S_PULL: if (fetch.ready) begin
          if (all_fed) begin
            stop_feed_uut_o <= 1'b1;
            done_o          <= 1'b1;
            state           <= S_IDLE;
          end else begin
            state <= S_WAIT;
          end
        end
        S_WAIT: if (fetch.byte_valid) begin
          byte_cnt <= byte_cnt + 32'd1;
          lane     <= lane + 1'b1;
          state    <= (lane == LW'(`AT_FEED_BYTES - 1)) ? S_FEED : S_PULL;
        end
        S_FEED: if (!busy_uut_i) state <= S_PULL;
        default: state <= S_IDLE;
      endcase
    end
  end

  // first card byte ends up most significant
  always_ff @(posedge clk) begin
    if (state == S_WAIT && fetch.byte_valid) begin
      feed_data_uut_o <= {feed_data_uut_o[8*`AT_FEED_BYTES-9:0], fetch.data};
    end
  end

endmodule

// File: hw/result_checker.sv
// result checker
// waits for the UUT to end, fail or time out, then compares its
// result with the expected value and counts failed tests
`include "at_cfg.svh"

module result_checker (
  input  logic            clk,
  input  logic            rst,
  input  logic            start_i,
  input  at_pkg::result_t expected_i,
  input  logic            end_uut_i,
  input  logic            err_uut_i,
  input  at_pkg::result_t output_from_uut_i,
  output logic            done_o,
  output logic [31:0]     error_count_o
);

  localparam int unsigned TW = $clog2(`AT_TIMEOUT_CYCLES + 1);

  localparam logic [1:0] C_IDLE    = 2'd0;
  localparam logic [1:0] C_WAIT    = 2'd1;
  localparam logic [1:0] C_COMPARE = 2'd2;

  logic [1:0]      state;
  logic [TW-1:0]   timer;
  logic            timed_out;
  logic            fail_q;
  at_pkg::result_t result_q;

  assign timed_out = timer == TW'(`AT_TIMEOUT_CYCLES - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= C_IDLE;
      timer         <= '0;
      fail_q        <= 1'b0;
      done_o        <= 1'b0;
      error_count_o <= '0;
    end else begin
      done_o <= 1'b0;
      case (state)
        C_IDLE: if (start_i) begin
          timer <= '0;
          state <= C_WAIT;
        end
        C_WAIT: begin
          timer <= timer + 1'b1;
          // end wins over a timeout in the same cycle
          if (end_uut_i || err_uut_i || timed_out) begin
            fail_q <= err_uut_i || !end_uut_i;
            state  <= C_COMPARE;
          end
        end
        C_COMPARE: begin
          if (fail_q || result_q != expected_i) error_count_o <= error_count_o + 32'd1;
          done_o <= 1'b1;
          state  <= C_IDLE;
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == C_WAIT) result_q <= output_from_uut_i;
  end

endmodule

// File: hw/sd_byte_fetcher.sv
// sd byte fetcher
// turns open, pull and close requests into the sd host busy-level
// handshake and registers each received byte
module sd_byte_fetcher (
  input  logic                clk,
  input  logic                rst,
  sd_fetch_if.fetcher         fetch,
  input  logic                spi_busy_i,
  input  at_pkg::byte_t       spi_data_out_i,
  output at_pkg::block_addr_t spi_block_addr_o,
  output logic                spi_r_block_o,
  output logic                spi_r_multi_block_o,
  output logic                spi_r_byte_o
);

  localparam logic [2:0] F_IDLE    = 3'd0;
  localparam logic [2:0] F_OPEN_HI = 3'd1;
  localparam logic [2:0] F_OPEN_LO = 3'd2;
  localparam logic [2:0] F_READY   = 3'd3;
  localparam logic [2:0] F_BYTE_HI = 3'd4;
  localparam logic [2:0] F_BYTE_LO = 3'd5;

  logic [2:0] state;

  assign fetch.ready = (state == F_IDLE) || (state == F_READY);

  //////////////////////////////////////////////////
  // session and byte handshake
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state               <= F_IDLE;
      spi_r_block_o       <= 1'b0;
      spi_r_multi_block_o <= 1'b0;
      spi_r_byte_o        <= 1'b0;
      fetch.byte_valid    <= 1'b0;
    end else begin
      fetch.byte_valid <= 1'b0;
      case (state)
        F_IDLE: if (fetch.open) begin
          spi_r_block_o       <= !fetch.multi;
          spi_r_multi_block_o <= fetch.multi;
          state               <= F_OPEN_HI;
        end
        // host acknowledges the block command with a busy pulse
        F_OPEN_HI: if (spi_busy_i) state <= F_OPEN_LO;
        F_OPEN_LO: if (!spi_busy_i) state <= F_READY;
        F_READY: begin
          if (fetch.close) begin
            spi_r_block_o       <= 1'b0;
            spi_r_multi_block_o <= 1'b0;
            state               <= F_IDLE;
          end else if (fetch.pull) begin
            spi_r_byte_o <= 1'b1;
            state        <= F_BYTE_HI;
          end
        end
        F_BYTE_HI: if (spi_busy_i) begin
          spi_r_byte_o <= 1'b0;
          state        <= F_BYTE_LO;
        end
        F_BYTE_LO: if (!spi_busy_i) begin
          fetch.byte_valid <= 1'b1;
          state            <= F_READY;
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  // address held for the whole session, byte captured as busy drops
  always_ff @(posedge clk) begin
    if (state == F_IDLE && fetch.open) spi_block_addr_o <= fetch.block_addr;
    if (state == F_BYTE_LO && !spi_busy_i) fetch.data <= spi_data_out_i;
  end

endmodule

// File: hw/sd_fetch_if.sv
// byte fetch link between a requester and the sd byte fetcher
// open/close bracket a read session, pull asks for one byte
interface sd_fetch_if;

  // requester side
  logic               open;
  logic               multi;
  at_pkg::block_addr_t block_addr;
  logic               pull;
  logic               close;

  // fetcher side
  logic               ready;
  logic               byte_valid;
  at_pkg::byte_t      data;

  modport requester (
    output open, multi, block_addr, pull, close,
    input  ready, byte_valid, data
  );

  modport fetcher (
    input  open, multi, block_addr, pull, close,
    output ready, byte_valid, data
  );

endinterface

// File: hw/test_sequencer.sv
// test sequencer
// phase machine over sd host reset, header read, feed, result check
// and block chaining; shares one fetch port between reader and streamer
`include "at_cfg.svh"

module test_sequencer (
  input  logic               clk,
  input  logic               rst,
  sd_fetch_if.requester      fetch,
  input  logic               spi_busy_i,
  output logic               spi_rst_o,
  output logic               rst_uut_o,
  input  logic               busy_uut_i,
  input  logic               end_uut_i,
  input  logic               err_uut_i,
  input  at_pkg::result_t    output_from_uut_i,
  output at_pkg::feed_word_t feed_data_uut_o,
  output logic               feed_data_control_uut_o,
  output logic               stop_feed_uut_o,
  output logic [31:0]        error_count_o,
  output logic [31:0]        tests_done_o,
  output logic               halted_o
);

  at_pkg::phase_e      phase;
  at_pkg::block_addr_t cur_block;
  at_pkg::ctrl_block_u hdr;
  logic                busy_seen;
  logic                rd_start, rd_done, sig_ok;
  logic                fd_start, fd_done;
  logic                chk_start, chk_done;

  sd_fetch_if rd_if ();
  sd_fetch_if fd_if ();

  ctrl_block_reader u_reader (
    .clk, .rst, .start_i(rd_start), .block_addr_i(cur_block),
    .fetch(rd_if.requester), .hdr_o(hdr), .done_o(rd_done), .sig_ok_o(sig_ok)
  );

  feed_streamer u_streamer (
    .clk, .rst, .start_i(fd_start), .block_addr_i(cur_block + 32'd1),
    .total_bytes_i(hdr.fields.total_bytes), .fetch(fd_if.requester),
    .busy_uut_i, .feed_data_uut_o, .feed_data_control_uut_o,
    .stop_feed_uut_o, .done_o(fd_done)
  );

  result_checker u_checker (
    .clk, .rst, .start_i(chk_start), .expected_i(hdr.fields.expected),
    .end_uut_i, .err_uut_i, .output_from_uut_i, .done_o(chk_done), .error_count_o
  );

  //////////////////////////////////////////////////
  // fetch port sharing
  //////////////////////////////////////////////////
  always_comb begin
    fetch.open       = 1'b0;
    fetch.multi      = 1'b0;
    fetch.block_addr = cur_block;
    fetch.pull       = 1'b0;
    fetch.close      = 1'b0;
    case (phase)
      at_pkg::READ_HDR: begin
        fetch.open       = rd_if.open;
        fetch.multi      = rd_if.multi;
        fetch.block_addr = rd_if.block_addr;
        fetch.pull       = rd_if.pull;
        fetch.close      = rd_if.close;
      end
      at_pkg::FEED: begin
        fetch.open       = fd_if.open;
        fetch.multi      = fd_if.multi;
        fetch.block_addr = fd_if.block_addr;
        fetch.pull       = fd_if.pull;
        fetch.close      = fd_if.close;
      end
      default: ;
    endcase
  end

  // responses go to both, the idle one ignores them
  assign rd_if.ready      = fetch.ready;
  assign rd_if.byte_valid = fetch.byte_valid;
  assign rd_if.data       = fetch.data;
  assign fd_if.ready      = fetch.ready;
  assign fd_if.byte_valid = fetch.byte_valid;
  assign fd_if.data       = fetch.data;

  assign spi_rst_o = phase == at_pkg::INIT;
  assign rst_uut_o = !(phase == at_pkg::FEED || phase == at_pkg::WAIT_RESULT);
  assign halted_o  = phase == at_pkg::HALT;

  //////////////////////////////////////////////////
  // phase machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      phase        <= at_pkg::INIT;
      cur_block    <= `AT_START_BLOCK;
      busy_seen    <= 1'b0;
      rd_start     <= 1'b0;
      fd_start     <= 1'b0;
      chk_start    <= 1'b0;
      tests_done_o <= '0;
    end else begin
      rd_start  <= 1'b0;
      fd_start  <= 1'b0;
      chk_start <= 1'b0;
      case (phase)
        // sd host signals its own reset with one busy pulse
        at_pkg::INIT: begin
          if (spi_busy_i) busy_seen <= 1'b1;
          if (busy_seen && !spi_busy_i) begin
            rd_start <= 1'b1;
            phase    <= at_pkg::READ_HDR;
          end
        end
        at_pkg::READ_HDR: if (rd_done) begin
          fd_start <= sig_ok;
          phase    <= sig_ok ? at_pkg::FEED : at_pkg::HALT;
        end
        at_pkg::FEED: if (fd_done) begin
          chk_start <= 1'b1;
          phase     <= at_pkg::WAIT_RESULT;
        end
        at_pkg::WAIT_RESULT: if (chk_done) begin
          tests_done_o <= tests_done_o + 32'd1;
          phase        <= at_pkg::NEXT;
        end
        at_pkg::NEXT: begin
          cur_block <= hdr.fields.next_block;
          rd_start  <= 1'b1;
          phase     <= at_pkg::READ_HDR;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: test/autotest_props.sv
// autotest assertions
// UUT strobe rules and sd host read levels, bound into the top level
module autotest_props (
  input logic clk_i,
  input logic rst_i,
  input logic busy_uut_i,
  input logic feed_strobe_i,
  input logic stop_feed_i,
  input logic r_block_i,
  input logic r_multi_i,
  input logic r_byte_i
);

  // number of property failures so far
  int unsigned fail_count = 0;

  // word strobe only while the UUT is free
  strobe_not_busy: assert property (
    @(posedge clk_i) disable iff (rst_i) feed_strobe_i |-> !busy_uut_i
  ) else begin
    $error("feed strobe while busy_uut_i is high");
    fail_count++;
  end

  // byte request only inside an open read session
  byte_in_session: assert property (
    @(posedge clk_i) disable iff (rst_i) r_byte_i |-> (r_block_i || r_multi_i)
  ) else begin
    $error("spi_r_byte_o high without a read level");
    fail_count++;
  end

  stop_one_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i) stop_feed_i |=> !stop_feed_i
  ) else begin
    $error("stop_feed_uut_o longer than one cycle");
    fail_count++;
  end

endmodule

bind autotest_top autotest_props u_props (
  .clk_i         (clk),
  .rst_i         (rst),
  .busy_uut_i    (busy_uut_i),
  .feed_strobe_i (feed_data_control_uut_o),
  .stop_feed_i   (stop_feed_uut_o),
  .r_block_i     (spi_r_block_o),
  .r_multi_i     (spi_r_multi_block_o),
  .r_byte_i      (spi_r_byte_o)
);

// File: test/tb_autotest.sv
// autotest testbench
// sd card and UUT models serve a random chain of control blocks,
// checks cover feed words, counters and the order of block reads
`include "at_cfg.svh"

module tb_autotest;

  localparam int FW          = 8 * `AT_FEED_BYTES;
  localparam int RW          = 8 * `AT_RESULT_BYTES;
  localparam int BB          = `AT_BLOCK_BYTES;
  localparam int TEST_CYCLES = 40000;
  localparam int HALT_CYCLES = 10000;

  logic          clk;
  logic          rst;
  logic          spi_busy;
  logic [7:0]    spi_data;
  logic [31:0]   spi_block_addr;
  logic          spi_r_block;
  logic          spi_r_byte;
  logic          spi_r_multi;
  logic          spi_rst;
  logic          rst_uut;
  logic          busy_uut;
  logic          end_uut;
  logic          err_uut;
  logic [FW-1:0] feed_data;
  logic          feed_ctrl;
  logic          stop_feed;
  logic [RW-1:0] uut_acc;
  logic [31:0]   error_count;
  logic [31:0]   tests_done;
  logic          halted;

  // test modes are 0 pass, 1 bad expected, 2 uut error and 3 no end
  int            num_tests;
  int            cur_test;
  int            t_words [6];
  int            t_mode [6];
  logic [31:0]   sess_addr_exp [$];
  bit            sess_multi_exp [$];
  logic [FW-1:0] words_exp [$];

  // card model
  logic [7:0]    card [longint];
  int            card_state;
  int            card_dly;
  bit            card_for_byte;
  bit            session;
  bit            rst_acked;
  longint        rd_ptr;
  logic [31:0]   sess_addr [$];
  bit            sess_multi [$];

  // UUT model
  bit            feed_seen;
  logic [FW-1:0] feed_word_seen;
  bit            stop_seen;
  int            busy_cnt;
  int            fin_cnt;
  int            got_words;

  int            checks;
  int            failures;

  autotest_top UUT (
    .clk                     (clk),
    .rst                     (rst),
    .spi_busy_i              (spi_busy),
    .spi_data_out_i          (spi_data),
    .spi_block_addr_o        (spi_block_addr),
    .spi_r_block_o           (spi_r_block),
    .spi_r_byte_o            (spi_r_byte),
    .spi_r_multi_block_o     (spi_r_multi),
    .spi_rst_o               (spi_rst),
    .rst_uut_o               (rst_uut),
    .busy_uut_i              (busy_uut),
    .end_uut_i               (end_uut),
    .err_uut_i               (err_uut),
    .feed_data_uut_o         (feed_data),
    .feed_data_control_uut_o (feed_ctrl),
    .stop_feed_uut_o         (stop_feed),
    .output_from_uut_i       (uut_acc),
    .error_count_o           (error_count),
    .tests_done_o            (tests_done),
    .halted_o                (halted)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
      failures++;
    end
  endtask

  // big-endian with the first byte at the lowest card offset
  task automatic put_bytes(input longint addr, input logic [63:0] val, input int n);
    int b;
    for (b = 0; b < n; b++) begin
      card[addr + b] = val[8*(n-1-b) +: 8];
    end
  endtask

  function automatic logic [7:0] card_byte_at(input longint addr);
    return card.exists(addr) ? card[addr] : 8'h00;
  endfunction

  function automatic string mode_name(input int mode);
    case (mode)
      0: return "pass";
      1: return "bad expected";
      2: return "uut error";
      default: return "no end";
    endcase
  endfunction

  //////////////////////////////////////////////////
  // random chain of control and feed blocks
  //////////////////////////////////////////////////
  task automatic build_chain();
    logic [31:0]   blk;
    logic [31:0]   next;
    logic [FW-1:0] w;
    logic [RW-1:0] sum;
    int            hang_at;
    int            nblk;
    int            i;
    int            j;
    blk       = `AT_START_BLOCK;
    num_tests = $urandom_range(3, 5);
    hang_at   = $urandom_range(0, 2 * num_tests);
    for (i = 0; i < num_tests; i++) begin
      t_words[i] = $urandom_range(1, 160);
      t_mode[i]  = (i == hang_at) ? 3 : $urandom_range(0, 2);
      sum        = '0;
      for (j = 0; j < t_words[i]; j++) begin
        w = $urandom;
        words_exp.push_back(w);
        sum ^= RW'(w);
        put_bytes(longint'(blk + 1) * BB + j * `AT_FEED_BYTES, w, `AT_FEED_BYTES);
      end
      nblk = (t_words[i] * `AT_FEED_BYTES + BB - 1) / BB;
      next = blk + 1 + nblk + $urandom_range(0, 3);
      if (t_mode[i] == 1) sum ^= RW'($urandom | 1);
      put_bytes(longint'(blk) * BB, `AT_SIGNATURE, 4);
      put_bytes(longint'(blk) * BB + 4, next, 4);
      put_bytes(longint'(blk) * BB + 8, t_words[i] * `AT_FEED_BYTES, 4);
      put_bytes(longint'(blk) * BB + 12, sum, `AT_RESULT_BYTES);
      sess_addr_exp.push_back(blk);
      sess_multi_exp.push_back(1'b0);
      sess_addr_exp.push_back(blk + 1);
      sess_multi_exp.push_back(1'b1);
      blk = next;
    end
    // end of chain
    put_bytes(longint'(blk) * BB, ~`AT_SIGNATURE, 4);
    sess_addr_exp.push_back(blk);
    sess_multi_exp.push_back(1'b0);
  endtask

  //////////////////////////////////////////////////
  // sd host model with one busy pulse per command
  //////////////////////////////////////////////////
  task automatic start_busy(input bit for_byte);
    card_for_byte = for_byte;
    card_dly      = $urandom_range(1, 3);
    card_state    = 1;
  endtask

  always @(posedge clk) begin
    #1;
    if (rst) begin
      card_state = 0;
      spi_busy   = 1'b0;
      session    = 0;
      rst_acked  = 0;
    end else if (card_state == 1) begin
      card_dly--;
      if (card_dly == 0) begin
        spi_busy   = 1'b1;
        card_dly   = $urandom_range(1, 3);
        card_state = 2;
      end
    end else if (card_state == 2) begin
      card_dly--;
      if (card_dly == 0) begin
        spi_busy   = 1'b0;
        card_state = 0;
        if (card_for_byte) begin
          spi_data = card_byte_at(rd_ptr);
          rd_ptr++;
        end
      end
    end else if (spi_rst && !rst_acked) begin
      rst_acked = 1;
      start_busy(1'b0);
    end else if ((spi_r_block || spi_r_multi) && !session) begin
      session = 1;
      sess_addr.push_back(spi_block_addr);
      sess_multi.push_back(spi_r_multi);
      rd_ptr = longint'(spi_block_addr) * BB;
      start_busy(1'b0);
    end else if (!spi_r_block && !spi_r_multi) begin
      session = 0;
    end else if (spi_r_byte) begin
      start_busy(1'b1);
    end
  end

  //////////////////////////////////////////////////
  // UUT model whose result is the XOR of all fed words
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (feed_ctrl) begin
      check_eq("busy_uut_i", busy_uut, 1'b0);
      feed_seen      = 1;
      feed_word_seen = feed_data;
    end
    if (stop_feed) stop_seen = 1;
  end

  always @(posedge clk) begin
    #1;
    if (rst || rst_uut) begin
      busy_uut  = 1'b0;
      end_uut   = 1'b0;
      err_uut   = 1'b0;
      uut_acc   = '0;
      busy_cnt  = 0;
      fin_cnt   = 0;
      feed_seen = 0;
      stop_seen = 0;
    end else begin
      if (feed_seen) begin
        feed_seen = 0;
        got_words++;
        uut_acc ^= RW'(feed_word_seen);
        assert (words_exp.size() != 0) else begin
          $display("unexpected extra feed word %0h at t=%0t", feed_word_seen, $time);
          failures++;
        end
        if (words_exp.size() != 0) begin
          check_eq("feed_data_uut_o", feed_word_seen, words_exp.pop_front());
        end
        busy_cnt = $urandom_range(0, 4);
      end
      busy_uut = busy_cnt > 0;
      if (busy_cnt > 0) busy_cnt--;
      if (stop_seen) begin
        stop_seen = 0;
        fin_cnt   = $urandom_range(1, 20);
      end else if (fin_cnt > 0) begin
        fin_cnt--;
        if (fin_cnt == 0 && t_mode[cur_test] < 2) end_uut = 1'b1;
        if (fin_cnt == 0 && t_mode[cur_test] == 2) err_uut = 1'b1;
      end
    end
  end

  task automatic wait_test_done(input int target, output bit ok);
    int n;
    n  = 0;
    ok = 0;
    while (!ok && !halted && n < TEST_CYCLES) begin
      @(negedge clk);
      n++;
      ok = tests_done == 32'(target);
    end
    if (!ok && halted) begin
      $display("run halted after %0d tests, %0d expected", tests_done, num_tests);
      failures++;
    end else if (!ok) begin
      $display("timeout: test %0d did not finish in %0d cycles", target - 1, TEST_CYCLES);
      failures++;
    end
  endtask

  task automatic wait_halt(output bit ok);
    int n;
    n  = 0;
    ok = 0;
    while (!ok && n < HALT_CYCLES) begin
      @(negedge clk);
      n++;
      ok = halted;
    end
    if (!ok) begin
      $display("timeout: halted_o never rose at the bad signature");
      failures++;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    int          i;
    int          n_sess;
    int          words_before;
    logic [31:0] errs_before;
    bit          ok;
    bit          aborted;
    rst       = 1'b1;
    spi_busy  = 1'b0;
    spi_data  = 8'h00;
    busy_uut  = 1'b0;
    end_uut   = 1'b0;
    err_uut   = 1'b0;
    uut_acc   = '0;
    checks    = 0;
    failures  = 0;
    cur_test  = 0;
    got_words = 0;
    aborted   = 0;
    void'($urandom(32'h49a1));
    build_chain();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_eq("spi_r_block_o", spi_r_block, 1'b0);
    check_eq("spi_r_byte_o", spi_r_byte, 1'b0);
    check_eq("spi_r_multi_block_o", spi_r_multi, 1'b0);
    check_eq("feed_data_control_uut_o", feed_ctrl, 1'b0);
    check_eq("stop_feed_uut_o", stop_feed, 1'b0);
    check_eq("halted_o", halted, 1'b0);
    check_eq("error_count_o", error_count, 0);
    check_eq("tests_done_o", tests_done, 0);
    check_eq("spi_rst_o", spi_rst, 1'b1);
    check_eq("rst_uut_o", rst_uut, 1'b1);
    $display("reset: %0d tests in chain", num_tests);
    for (i = 0; i < num_tests && !aborted; i++) begin
      words_before = got_words;
      errs_before  = error_count;
      wait_test_done(i + 1, ok);
      if (!ok) begin
        aborted = 1;
      end else begin
        check_eq("feed strobes", got_words - words_before, t_words[i]);
        check_eq("error_count_o", error_count, errs_before + (t_mode[i] != 0));
        $display("test %0d: %0d words, %s, error_count %0d, failures so far %0d",
                 i, t_words[i], mode_name(t_mode[i]), error_count, failures);
        cur_test = i + 1;
      end
    end
    if (!aborted) begin
      wait_halt(ok);
      if (ok) begin
        check_eq("tests_done_o", tests_done, num_tests);
        n_sess = sess_addr.size();
        repeat (200) @(negedge clk);
        check_eq("read sessions after halt", sess_addr.size(), n_sess);
        check_eq("read sessions", sess_addr.size(), sess_addr_exp.size());
        for (i = 0; i < sess_addr_exp.size() && i < sess_addr.size(); i++) begin
          check_eq("spi_block_addr_o", sess_addr[i], sess_addr_exp[i]);
          check_eq("spi_r_multi_block_o", sess_multi[i], sess_multi_exp[i]);
        end
        check_eq("words never fed", words_exp.size(), 0);
      end
    end
    assert (UUT.u_props.fail_count == 0) else begin
      $display("%0d bound property checks failed", UUT.u_props.fail_count);
      failures++;
    end
    $display("checks %0d, failures %0d, tests done %0d of %0d",
             checks, failures, tests_done, num_tests);
    if (failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
